//--- filelist.f
+incdir+include
verilog/cdc_pkg.sv
verilog/ackdone_pkg.sv
verilog/async_fifo.sv
verilog/flag_sync.sv
verilog/doneaddr_broadcast.sv
verilog/ack_done_generator.sv
test/ack_done_asserts.sv
test/tb_ack_done_generator.sv

//--- Makefile
SIM  := obj_dir/Vtb_ack_done_generator
SRCS := $(wildcard verilog/*.sv) $(wildcard test/*.sv) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) filelist.f
	verilator --binary --timing --assert -f filelist.f \
		--top-module tb_ack_done_generator -o Vtb_ack_done_generator

sim.log: $(SIM) test/ack_done_stimulus.txt
	./$(SIM) > sim.log 2>&1 || true

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test FAILED" sim.log || ! grep -q "Test OK" sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- test/ack_done_stimulus.txt
# op value expected, all values in hex
# A ack {allow,addr}, N nack out word, S stall {t3,t2,t1,t0,hdr,nack}, W cycles, F count accepted
A 000012300000 00123
A 80007ff00000 107ff
N ffffffffffff 47ffffffffff
N 800000000001 000000000001
A ffffffffffff 10fff
N 3aaaaaaaaaaa 02aaaaaaaaaa
A 0000fff55555 00fff
N 4123456789ab 4123456789ab
S 3e 0
A 7fff00100000 00001
A 000045600000 00456
A 80000aa00000 100aa
W 10 0
S 0a 0
A 0000bcd00000 00bcd
N 5c0000000000 440000000000
A 00000ef00000 000ef
W 20 0
S 00 0
W 40 0
S 01 0
F 258 200
S 00 0
A 800031400000 10314
N 000000000000 000000000000
A 123456789abc 00567

//--- test/tb_ack_done_generator.sv
`timescale 1ns/100ps
`include "ackdone_params.svh"

module tb_ack_done_generator
    import ackdone_pkg::*;
();

    logic aclk = 1'b0;
    logic memclk = 1'b0;
    logic arst_n;

    stream_word_t s_ack_tdata;
    logic         s_ack_tvalid;
    logic         s_ack_tready;
    stream_word_t s_nack_tdata;
    logic         s_nack_tvalid;
    logic         s_nack_tready;
    stream_word_t m_nack_tdata;
    logic         m_nack_tvalid;
    logic         nack_ready;
    logic         allow;
    done_word_t   out_data [`ACKDONE_NUM_DONE];
    logic [`ACKDONE_NUM_DONE-1:0] out_valid;
    logic [`ACKDONE_NUM_DONE-1:0] addr_ready;

    // scoreboards, index 0 of the address queues is the header stream
    stream_word_t nack_q [$];
    done_word_t   addr_q [`ACKDONE_NUM_DONE][$];
    int           allow_expected = 0;
    int           allow_seen = 0;

    // bit 0 stalls the nack consumer, bits 1 to 5 the done outputs
    logic [5:0]   stall_mask;
    integer       seed;
    integer       rnd;
    int           cycle_count = 0;
    int           cycle_limit = 0;
    stream_word_t mon_nack;

    byte          op_q [$];
    stream_word_t val_q [$];
    stream_word_t exp_q [$];

    always #4 aclk = ~aclk;
    always #5 memclk = ~memclk;

    ack_done_generator dut0 (
        .aclk             (aclk),
        .arst_n           (arst_n),
        .s_ack_tdata      (s_ack_tdata),
        .s_ack_tvalid     (s_ack_tvalid),
        .s_ack_tready     (s_ack_tready),
        .s_nack_tdata     (s_nack_tdata),
        .s_nack_tvalid    (s_nack_tvalid),
        .s_nack_tready    (s_nack_tready),
        .memclk           (memclk),
        .m_nack_tdata     (m_nack_tdata),
        .m_nack_tvalid    (m_nack_tvalid),
        .m_nack_tready    (nack_ready),
        .allow            (allow),
        .m_hdraddr_tdata  (out_data[0]),
        .m_hdraddr_tvalid (out_valid[0]),
        .m_hdraddr_tready (addr_ready[0]),
        .m_t0addr_tdata   (out_data[1]),
        .m_t0addr_tvalid  (out_valid[1]),
        .m_t0addr_tready  (addr_ready[1]),
        .m_t1addr_tdata   (out_data[2]),
        .m_t1addr_tvalid  (out_valid[2]),
        .m_t1addr_tready  (addr_ready[2]),
        .m_t2addr_tdata   (out_data[3]),
        .m_t2addr_tvalid  (out_valid[3]),
        .m_t2addr_tready  (addr_ready[3]),
        .m_t3addr_tdata   (out_data[4]),
        .m_t3addr_tvalid  (out_valid[4]),
        .m_t3addr_tready  (addr_ready[4])
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            stop_with_failure("value mismatch");
        end
    endtask

    function automatic string out_name(input int idx);
        case (idx)
            0: return "hdr_addr";
            1: return "t0_addr";
            2: return "t1_addr";
            3: return "t2_addr";
            default: return "t3_addr";
        endcase
    endfunction

    // nack rule: flag bit 46 and low field 42..0 survive, the rest is zero
    function automatic stream_word_t nack_expect(input stream_word_t w);
        stream_word_t r;
        r = '0;
        r[46] = w[46];
        r[42:0] = w[42:0];
        return r;
    endfunction

    function automatic stream_word_t fill_word(input int idx);
        return {idx[15:0] ^ 16'h5a5a, 32'(idx) * 32'h9e3779b1};
    endfunction

    function automatic int pending_words();
        int n;
        n = nack_q.size();
        for (int i = 0; i < `ACKDONE_NUM_DONE; i++) begin
            n += addr_q[i].size();
        end
        return n;
    endfunction

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            stop_with_failure("run timed out waiting for the DUT");
        end
    end

    // consumers: score what transfers at this edge, then pick new readies
    always @(posedge memclk) begin
        if (arst_n) begin
            if (m_nack_tvalid && nack_ready) begin
                if (nack_q.size() == 0) begin
                    stop_with_failure("nack output appeared with no nack pending");
                end
                mon_nack = nack_q.pop_front();
                check("nack_out", 64'(mon_nack), 64'(m_nack_tdata));
            end
            for (int i = 0; i < `ACKDONE_NUM_DONE; i++) begin
                if (out_valid[i] && addr_ready[i]) begin
                    if (addr_q[i].size() == 0) begin
                        stop_with_failure({out_name(i), " sent an address with none pending"});
                    end
                    check(out_name(i), 64'(addr_q[i].pop_front()), 64'(out_data[i]));
                end
            end
            if (allow) begin
                allow_seen++;
            end
            rnd = $random(seed);
            nack_ready <= !stall_mask[0] && (rnd[1:0] != 2'b00);
            for (int i = 0; i < `ACKDONE_NUM_DONE; i++) begin
                addr_ready[i] <= !stall_mask[i+1] && (rnd[2*i+3 -: 2] != 2'b00);
            end
        end
    end

    task automatic send_ack(input stream_word_t word, input stream_word_t expv);
        for (int i = 0; i < `ACKDONE_NUM_DONE; i++) begin
            addr_q[i].push_back(expv[15:0]);
        end
        if (expv[16]) begin
            allow_expected++;
        end
        @(posedge aclk);
        s_ack_tdata  <= word;
        s_ack_tvalid <= 1'b1;
        do @(posedge aclk); while (!s_ack_tready);
        s_ack_tvalid <= 1'b0;
        // keeps allow pulses far enough apart for the toggle crossing
        if (expv[16]) begin
            repeat (6) @(posedge aclk);
        end
    endtask

    task automatic send_nack(input stream_word_t word, input stream_word_t expv);
        nack_q.push_back(expv);
        @(posedge aclk);
        s_nack_tdata  <= word;
        s_nack_tvalid <= 1'b1;
        do @(posedge aclk); while (!s_nack_tready);
        s_nack_tvalid <= 1'b0;
    endtask

    // fills the nack fifo against a stalled consumer, then drains it
    task automatic fill_nacks(input int count, input int expect_full);
        int sent;
        int idle;
        sent = 0;
        idle = 0;
        @(posedge aclk);
        s_nack_tdata  <= fill_word(0);
        s_nack_tvalid <= 1'b1;
        while (idle < 16 && sent < count) begin
            @(posedge aclk);
            if (s_nack_tready) begin
                nack_q.push_back(nack_expect(fill_word(sent)));
                sent++;
                s_nack_tdata <= fill_word(sent);
                idle = 0;
            end else begin
                idle++;
            end
        end
        check("nack_fill_count", 64'(expect_full), 64'(sent));
        stall_mask[0] = 1'b0;
        while (sent < count) begin
            @(posedge aclk);
            if (s_nack_tready) begin
                nack_q.push_back(nack_expect(fill_word(sent)));
                sent++;
                s_nack_tdata <= fill_word(sent);
            end
        end
        s_nack_tvalid <= 1'b0;
    endtask

    // while a stalled output still holds the head word, every output
    // that is not stalled must already have taken it
    task automatic check_stall_bypass();
        logic [`ACKDONE_NUM_DONE-1:0] stalled;
        stalled = stall_mask[5:1];
        if ((out_valid & stalled) != '0) begin
            for (int i = 0; i < `ACKDONE_NUM_DONE; i++) begin
                if (!stalled[i]) begin
                    check({out_name(i), "_past_stall"}, 64'(0), 64'(out_valid[i]));
                end
            end
        end
    endtask

    initial begin
        int fd;
        int code;
        byte op;
        stream_word_t val;
        stream_word_t expv;
        string line;
        arst_n        = 1'b0;
        s_ack_tdata   = '0;
        s_ack_tvalid  = 1'b0;
        s_nack_tdata  = '0;
        s_nack_tvalid = 1'b0;
        nack_ready    = 1'b0;
        addr_ready    = '0;
        stall_mask    = '0;
        seed          = 79;

        fd = $fopen("test/ack_done_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open the stimulus file");
        end
        cycle_limit = 400;
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) begin
                break;
            end
            if (op == "#") begin
                code = $fgets(line, fd);
            end else begin
                code = $fscanf(fd, " %h %h", val, expv);
                if (code != 2) begin
                    stop_with_failure("stimulus file line is malformed");
                end
                op_q.push_back(op);
                val_q.push_back(val);
                exp_q.push_back(expv);
                cycle_limit += 20;
                if (op == "W") begin
                    cycle_limit += int'(val);
                end else if (op == "F") begin
                    cycle_limit += 20 * int'(val);
                end
            end
        end
        $fclose(fd);

        // release between clock edges of both domains
        repeat (4) @(posedge aclk);
        #1 arst_n = 1'b1;

        @(posedge aclk);
        check("reset_nack_valid", 64'(0), 64'(m_nack_tvalid));
        check("reset_addr_valid", 64'(0), 64'(out_valid));
        check("reset_allow", 64'(0), 64'(allow));
        check("reset_ack_ready", 64'(1), 64'(s_ack_tready));
        check("reset_nack_ready", 64'(1), 64'(s_nack_tready));

        for (int k = 0; k < op_q.size(); k++) begin
            case (op_q[k])
                "A": send_ack(val_q[k], exp_q[k]);
                "N": send_nack(val_q[k], exp_q[k]);
                "S": stall_mask = val_q[k][5:0];
                "W": begin
                    repeat (int'(val_q[k])) @(posedge aclk);
                    check_stall_bypass();
                end
                "F": fill_nacks(int'(val_q[k]), int'(exp_q[k]));
                default: stop_with_failure("unknown operation in stimulus file");
            endcase
        end

        stall_mask = '0;
        while (pending_words() != 0 || allow_seen < allow_expected) begin
            @(posedge aclk);
        end
        repeat (10) @(posedge aclk);
        check("allow_count", 64'(allow_expected), 64'(allow_seen));
        $display("Test OK");
        $finish;
    end

endmodule

//--- test/ack_done_asserts.sv
`timescale 1ns/100ps
`include "ackdone_params.svh"

// protocol checks on the memclk side of the ack/nack crossing
module ack_done_asserts (
    input logic        memclk,
    input logic        arst_n,
    input logic        allow,
    input logic [47:0] m_nack_tdata,
    input logic        m_nack_tvalid,
    input logic        m_nack_tready,
    input logic [15:0] m_hdraddr_tdata,
    input logic        m_hdraddr_tvalid,
    input logic        m_hdraddr_tready,
    input logic [15:0] m_t0addr_tdata,
    input logic        m_t0addr_tvalid,
    input logic        m_t0addr_tready,
    input logic [15:0] m_t1addr_tdata,
    input logic        m_t1addr_tvalid,
    input logic        m_t1addr_tready,
    input logic [15:0] m_t2addr_tdata,
    input logic        m_t2addr_tvalid,
    input logic        m_t2addr_tready,
    input logic [15:0] m_t3addr_tdata,
    input logic        m_t3addr_tvalid,
    input logic        m_t3addr_tready
);

    // a stalled word must wait unchanged for its consumer
    nack_hold: assert property (@(posedge memclk) disable iff (!arst_n)
        m_nack_tvalid && !m_nack_tready |=> m_nack_tvalid && $stable(m_nack_tdata))
        else $error("nack output changed while stalled");
    hdr_hold: assert property (@(posedge memclk) disable iff (!arst_n)
        m_hdraddr_tvalid && !m_hdraddr_tready |=> m_hdraddr_tvalid && $stable(m_hdraddr_tdata))
        else $error("header address changed while stalled");
    t0_hold: assert property (@(posedge memclk) disable iff (!arst_n)
        m_t0addr_tvalid && !m_t0addr_tready |=> m_t0addr_tvalid && $stable(m_t0addr_tdata))
        else $error("tag 0 address changed while stalled");
    t1_hold: assert property (@(posedge memclk) disable iff (!arst_n)
        m_t1addr_tvalid && !m_t1addr_tready |=> m_t1addr_tvalid && $stable(m_t1addr_tdata))
        else $error("tag 1 address changed while stalled");
    t2_hold: assert property (@(posedge memclk) disable iff (!arst_n)
        m_t2addr_tvalid && !m_t2addr_tready |=> m_t2addr_tvalid && $stable(m_t2addr_tdata))
        else $error("tag 2 address changed while stalled");
    t3_hold: assert property (@(posedge memclk) disable iff (!arst_n)
        m_t3addr_tvalid && !m_t3addr_tready |=> m_t3addr_tvalid && $stable(m_t3addr_tdata))
        else $error("tag 3 address changed while stalled");

    allow_single: assert property (@(posedge memclk) disable iff (!arst_n)
        allow |=> !allow)
        else $error("allow held for more than one cycle");

    reset_quiet: assert property (@(posedge memclk)
        !arst_n |-> !(m_nack_tvalid || m_hdraddr_tvalid || m_t0addr_tvalid ||
                      m_t1addr_tvalid || m_t2addr_tvalid || m_t3addr_tvalid || allow))
        else $error("output valid during reset");

endmodule

bind ack_done_generator ack_done_asserts u_asserts (.*);

//--- verilog/ack_done_generator.sv
`timescale 1ns/100ps
`include "ackdone_params.svh"

// crosses acks and nacks from the ethernet clock into the memory clock
// nacks go through a small fifo with their constant bits removed
// acks keep only the done address, which is broadcast to the header
// and tag consumers, plus the allow bit that crosses as a pulse
module ack_done_generator
    import ackdone_pkg::*;
(
    // ethernet side
    input  logic         aclk,
    input  logic         arst_n,
    input  stream_word_t s_ack_tdata,
    input  logic         s_ack_tvalid,
    output logic         s_ack_tready,
    input  stream_word_t s_nack_tdata,
    input  logic         s_nack_tvalid,
    output logic         s_nack_tready,

    // memory side
    input  logic         memclk,
    output stream_word_t m_nack_tdata,
    output logic         m_nack_tvalid,
    input  logic         m_nack_tready,
    output logic         allow,
    output done_word_t   m_hdraddr_tdata,
    output logic         m_hdraddr_tvalid,
    input  logic         m_hdraddr_tready,
    output done_word_t   m_t0addr_tdata,
    output logic         m_t0addr_tvalid,
    input  logic         m_t0addr_tready,
    output done_word_t   m_t1addr_tdata,
    output logic         m_t1addr_tvalid,
    input  logic         m_t1addr_tready,
    output done_word_t   m_t2addr_tdata,
    output logic         m_t2addr_tvalid,
    input  logic         m_t2addr_tready,
    output done_word_t   m_t3addr_tdata,
    output logic         m_t3addr_tvalid,
    input  logic         m_t3addr_tready
);

    nack_packed_t nack_din;
    nack_packed_t nack_dout;
    logic         nack_full;

    done_addr_t   ack_din;
    done_addr_t   ack_dout;
    logic         ack_full;
    logic         ack_valid;
    logic         ack_pop;
    done_word_t   ack_word;
    logic         allow_req;

    // broadcaster side, index 0 is the header stream
    done_word_t [`ACKDONE_NUM_DONE-1:0] bc_tdata;
    logic       [`ACKDONE_NUM_DONE-1:0] bc_tvalid;
    logic       [`ACKDONE_NUM_DONE-1:0] bc_tready;

    // nack path keeps the flag and the low field only
    assign nack_din      = {s_nack_tdata[`ACKDONE_NACK_FLAG_BIT],
                            s_nack_tdata[`ACKDONE_NACK_LOW_W-1:0]};
    assign s_nack_tready = ~nack_full;

    async_fifo #(
        .WIDTH      (`ACKDONE_NACK_LOW_W + 1),
        .DEPTH_LOG2 (`ACKDONE_NACK_DEPTH_LOG2)
    ) u_nack_fifo (
        .wr_clk (aclk),
        .arst_n (arst_n),
        .din    (nack_din),
        .wr_en  (s_nack_tvalid & ~nack_full),
        .full   (nack_full),
        .rd_clk (memclk),
        .dout   (nack_dout),
        .valid  (m_nack_tvalid),
        .rd_en  (m_nack_tvalid & m_nack_tready)
    );

    // rebuild the full nack with the dropped bits at zero
    always_comb begin
        m_nack_tdata = '0;
        m_nack_tdata[`ACKDONE_NACK_FLAG_BIT] = nack_dout[`ACKDONE_NACK_LOW_W];
        m_nack_tdata[`ACKDONE_NACK_LOW_W-1:0] = nack_dout[`ACKDONE_NACK_LOW_W-1:0];
    end

    // ack path stores only the done address, deep enough for all of them
    assign ack_din      = s_ack_tdata[`ACKDONE_ACK_ADDR_LSB +: `ACKDONE_DONE_ADDR_W];
    assign s_ack_tready = ~ack_full;

    async_fifo #(
        .WIDTH      (`ACKDONE_DONE_ADDR_W),
        .DEPTH_LOG2 (`ACKDONE_ACK_DEPTH_LOG2)
    ) u_ack_fifo (
        .wr_clk (aclk),
        .arst_n (arst_n),
        .din    (ack_din),
        .wr_en  (s_ack_tvalid & ~ack_full),
        .full   (ack_full),
        .rd_clk (memclk),
        .dout   (ack_dout),
        .valid  (ack_valid),
        .rd_en  (ack_pop)
    );

    assign ack_word = {{(`ACKDONE_ADDR_W - `ACKDONE_DONE_ADDR_W){1'b0}}, ack_dout};

    doneaddr_broadcast u_broadcast (
        .memclk   (memclk),
        .arst_n   (arst_n),
        .s_tdata  (ack_word),
        .s_tvalid (ack_valid),
        .s_tready (ack_pop),
        .m_tdata  (bc_tdata),
        .m_tvalid (bc_tvalid),
        .m_tready (bc_tready)
    );

    assign m_hdraddr_tdata  = bc_tdata[0];
    assign m_hdraddr_tvalid = bc_tvalid[0];
    assign m_t0addr_tdata   = bc_tdata[1];
    assign m_t0addr_tvalid  = bc_tvalid[1];
    assign m_t1addr_tdata   = bc_tdata[2];
    assign m_t1addr_tvalid  = bc_tvalid[2];
    assign m_t2addr_tdata   = bc_tdata[3];
    assign m_t2addr_tvalid  = bc_tvalid[3];
    assign m_t3addr_tdata   = bc_tdata[4];
    assign m_t3addr_tvalid  = bc_tvalid[4];
    assign bc_tready        = {m_t3addr_tready, m_t2addr_tready, m_t1addr_tready,
                               m_t0addr_tready, m_hdraddr_tready};

    // allow is taken at acceptance, not stored with the address
    assign allow_req = s_ack_tvalid & ~ack_full & s_ack_tdata[`ACKDONE_ALLOW_BIT];

    flag_sync u_allow_sync (
        .aclk      (aclk),
        .memclk    (memclk),
        .arst_n    (arst_n),
        .pulse_in  (allow_req),
        .pulse_out (allow)
    );

endmodule

//--- verilog/doneaddr_broadcast.sv
`timescale 1ns/100ps
`include "ackdone_params.svh"

// sends each done address once to every output stream
// outputs advance independently, so a fast consumer gets the
// word as soon as it is ready and only the input waits for the
// slowest one
module doneaddr_broadcast
    import ackdone_pkg::*;
(
    input  logic                                  memclk,
    input  logic                                  arst_n,

    input  done_word_t                            s_tdata,
    input  logic                                  s_tvalid,
    output logic                                  s_tready,

    output done_word_t [`ACKDONE_NUM_DONE-1:0]    m_tdata,
    output logic       [`ACKDONE_NUM_DONE-1:0]    m_tvalid,
    input  logic       [`ACKDONE_NUM_DONE-1:0]    m_tready
);

    // outputs that already have the current word
    logic [`ACKDONE_NUM_DONE-1:0] taken;
    // outputs that have the word by the end of this cycle
    logic [`ACKDONE_NUM_DONE-1:0] served;

    // every output sees the same word
    assign m_tdata  = {`ACKDONE_NUM_DONE{s_tdata}};
    assign m_tvalid = {`ACKDONE_NUM_DONE{s_tvalid}} & ~taken;

    assign served   = taken | (m_tvalid & m_tready);

    // the input word retires once the last output gets it
    assign s_tready = &served;

    always_ff @(posedge memclk or negedge arst_n) begin
        if (!arst_n) begin
            taken <= '0;
        end else if (s_tvalid && s_tready) begin
            // next word starts with nobody served
            taken <= '0;
        end else begin
            taken <= served;
        end
    end

endmodule

//--- verilog/flag_sync.sv
`timescale 1ns/100ps
`include "ackdone_params.svh"

// carries single-cycle pulses from aclk into memclk
// each input pulse flips a level, and the level change is
// turned back into a pulse on the far side
// pulses closer than a few memclk cycles would merge
module flag_sync (
    input  logic aclk,
    input  logic memclk,
    input  logic arst_n,
    input  logic pulse_in,
    output logic pulse_out
);

    logic       toggle;
    logic [2:0] toggle_sync;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            toggle <= 1'b0;
        end else begin
            toggle <= toggle ^ pulse_in;
        end
    end

    // stage 0 may go metastable, stages 1 and 2 give the edge
    always_ff @(posedge memclk or negedge arst_n) begin
        if (!arst_n) begin
            toggle_sync <= '0;
        end else begin
            toggle_sync <= {toggle_sync[1:0], toggle};
        end
    end

    // high for exactly one memclk cycle per toggle
    assign pulse_out = toggle_sync[2] ^ toggle_sync[1];

endmodule

//--- verilog/async_fifo.sv
`timescale 1ns/100ps
`include "ackdone_params.svh"

// dual-clock fifo with the head word falling through on the read side
// pointers cross between domains as gray codes through two flops
module async_fifo
    import cdc_pkg::*;
#(
    parameter int WIDTH      = `ACKDONE_NACK_LOW_W + 1,
    parameter int DEPTH_LOG2 = `ACKDONE_NACK_DEPTH_LOG2
) (
    input  logic             wr_clk,
    input  logic             arst_n,
    input  logic [WIDTH-1:0] din,
    input  logic             wr_en,
    output logic             full,

    input  logic             rd_clk,
    output logic [WIDTH-1:0] dout,
    output logic             valid,
    input  logic             rd_en
);

    // keeps pointers inside DEPTH_LOG2 + 1 bits so that the
    // upper bits of the shared pointer type stay zero
    localparam fifo_ptr_t PTR_MASK = fifo_ptr_t'((1 << (DEPTH_LOG2 + 1)) - 1);
    // a full fifo has the write pointer one lap ahead, which in gray
    // code shows as the two top bits inverted
    localparam gray_ptr_t FULL_FLIP = gray_ptr_t'(3 << (DEPTH_LOG2 - 1));

    logic [WIDTH-1:0] mem [0:(1 << DEPTH_LOG2) - 1];

    fifo_ptr_t wr_bin;
    fifo_ptr_t wr_bin_next;
    gray_ptr_t wr_gray;
    gray_ptr_t rd_gray_meta;
    gray_ptr_t rd_gray_sync;
    logic      wr_ok;

    fifo_ptr_t rd_bin;
    fifo_ptr_t rd_bin_next;
    gray_ptr_t rd_gray;
    gray_ptr_t wr_gray_meta;
    gray_ptr_t wr_gray_sync;
    logic      rd_ok;

    // write domain
    assign wr_ok       = wr_en & ~full;
    assign wr_bin_next = wr_ok ? ((wr_bin + fifo_ptr_t'(1)) & PTR_MASK) : wr_bin;

    always_ff @(posedge wr_clk) begin
        if (wr_ok) begin
            mem[wr_bin[DEPTH_LOG2-1:0]] <= din;
        end
    end

    always_ff @(posedge wr_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_bin       <= '0;
            wr_gray      <= '0;
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
            full         <= 1'b0;
        end else begin
            wr_bin       <= wr_bin_next;
            wr_gray      <= bin_to_gray(wr_bin_next);
            rd_gray_meta <= rd_gray;
            rd_gray_sync <= rd_gray_meta;
            // sees pops late, so full may linger but never drops early
            full         <= (bin_to_gray(wr_bin_next) == (rd_gray_sync ^ FULL_FLIP));
        end
    end

    // read domain
    // the read pointer moves on a pop, so the head slot stays
    // reserved until the consumer has taken it
    assign rd_ok       = rd_en & valid;
    assign rd_bin_next = rd_ok ? ((rd_bin + fifo_ptr_t'(1)) & PTR_MASK) : rd_bin;

    // head register, reloaded every cycle from the next head slot
    always_ff @(posedge rd_clk) begin
        dout <= mem[rd_bin_next[DEPTH_LOG2-1:0]];
    end

    always_ff @(posedge rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_bin       <= '0;
            rd_gray      <= '0;
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
            valid        <= 1'b0;
        end else begin
            rd_bin       <= rd_bin_next;
            rd_gray      <= bin_to_gray(rd_bin_next);
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
            // not empty once the synced write pointer is past the new head
            valid        <= (bin_to_gray(rd_bin_next) != wr_gray_sync);
        end
    end

endmodule

//--- verilog/ackdone_pkg.sv
`include "ackdone_params.svh"

// types for the ack/nack messages and the done addresses
package ackdone_pkg;

    // raw ack or nack word as it arrives in the ethernet domain
    typedef logic [`ACKDONE_STREAM_W-1:0] stream_word_t;

    // done address as it is stored in the ack fifo
    typedef logic [`ACKDONE_DONE_ADDR_W-1:0] done_addr_t;

    // done address as it leaves on each broadcast stream
    typedef logic [`ACKDONE_ADDR_W-1:0] done_word_t;

    // stored nack
    // the flag bit sits on top of the kept low field, the
    // constant bits of the message are dropped before the crossing
    typedef logic [`ACKDONE_NACK_LOW_W:0] nack_packed_t;

endpackage

//--- verilog/cdc_pkg.sv
`include "ackdone_params.svh"

// storage types for the clock-domain crossing fifos
package cdc_pkg;

    // binary pointer with wrap bit, sized for the deepest fifo
    typedef logic [`ACKDONE_ACK_DEPTH_LOG2:0] fifo_ptr_t;

    // gray coded copy of a pointer, the only form that crosses domains
    typedef logic [`ACKDONE_ACK_DEPTH_LOG2:0] gray_ptr_t;

    // only one bit changes per increment, so a half-captured
    // value is always either the old or the new pointer
    function automatic gray_ptr_t bin_to_gray(input fifo_ptr_t bin);
        return gray_ptr_t'(bin ^ (bin >> 1));
    endfunction

endpackage

//--- include/ackdone_params.svh
`ifndef ACKDONE_PARAMS_SVH
`define ACKDONE_PARAMS_SVH

// width of the ack and nack message streams
`define ACKDONE_STREAM_W 48
// width of each done-address output stream
`define ACKDONE_ADDR_W 16
// done address carried inside an ack
`define ACKDONE_DONE_ADDR_W 12
`define ACKDONE_ACK_ADDR_LSB 20
// ack bit that requests an allow pulse
`define ACKDONE_ALLOW_BIT 47
// nack fields that survive the crossing
`define ACKDONE_NACK_FLAG_BIT 46
`define ACKDONE_NACK_LOW_W 43
// fifo depths as log2 of the entry count
`define ACKDONE_ACK_DEPTH_LOG2 12
`define ACKDONE_NACK_DEPTH_LOG2 9
// header plus four tag streams
`define ACKDONE_NUM_DONE 5

`endif
